// ==== filelist.f ====
design/fmap_pkg.sv
design/axil_pkg.sv
design/axil_cfg_regs.sv
design/sweep_sequencer.sv
design/bram2_addr_gen.sv
design/addr_out_fifo.sv
design/bram_addr_top.sv
dv/tb_clock.sv
dv/addr_gen_properties.sv
dv/tb_top.sv

// ==== dv/tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_top
	import axil_pkg::*;
	import fmap_pkg::*;
();

	localparam int N_SWEEPS        = 40;
	localparam int N_READBACK      = 8;
	localparam int WATCHDOG_CYCLES = N_SWEEPS * 200 + 1000;
	localparam int MODE_FULL       = 0;
	localparam int MODE_RANDOM     = 1;
	localparam int MODE_STALL      = 2;

	logic        clk;
	logic        rst_n;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;
	addr_beat_t  out_beat;
	logic        out_valid;
	logic        out_ready;
	logic [31:0] stim_lfsr;
	logic [31:0] ready_lfsr;
	int          ready_mode;
	int          starts;
	addr_beat_t  beat_q[$];

	tb_clock i_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	bram_addr_top i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.axil_req  (axil_req),
		.axil_rsp  (axil_rsp),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] random_bits(inout logic [31:0] state, input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
			state = {state[30:0], fb};
			v     = {v[30:0], fb};
		end
		return v;
	endfunction

	// expected bram2 address, field sums wrap mod 32
	function automatic logic [ADDR_W-1:0] model_addr(input tile_cfg_t c, input int z);
		logic [FIELD_W-1:0] xr;
		logic [FIELD_W-1:0] yr;
		logic [FIELD_W-1:0] h;
		logic [FIELD_W-1:0] k;
		logic [FIELD_W-1:0] row;
		logic [FIELD_W-1:0] col;
		xr  = FIELD_W'(c.x_reg5);
		yr  = FIELD_W'(c.y_reg5);
		h   = xr >> 1;
		k   = yr >> 1;
		row = '0;
		col = '0;
		case (c.u)
			3'd2:
			begin
				row = FIELD_W'(c.x);
				col = FIELD_W'(c.y + 8 * c.l);
			end
			3'd4:
			begin
				row = FIELD_W'(c.x + c.j - 1);
				col = FIELD_W'(c.y + 8 * c.l);
			end
			// column quarter order starts at z = 2
			3'd5:
			begin
				row = FIELD_W'(xr + ((z >= 2 && z <= 5) ? 0 : 8));
				col = FIELD_W'(yr + 8 * ((z + 6) % 4));
			end
			3'd0:
			begin
				row = FIELD_W'(h + ((z == 6 || z == 7) ? 8 : 0));
				col = FIELD_W'(k + 8 * ((z + 6) % 4));
			end
			3'd1:
				if (z < 4)
				begin
					row = FIELD_W'(h + ((z < 2) ? 8 : 0));
					col = FIELD_W'(k + 8 * ((z + 6) % 4));
				end
			// 3, 6 and 7 start the quarters at z = 1
			default:
				if (z < 4)
				begin
					row = xr;
					col = FIELD_W'(yr + 8 * ((z + 3) % 4));
				end
		endcase
		return {row, col};
	endfunction

	task automatic fail_now(input string what);
		$display("[ERROR] %s", what);
		$display("Simulation FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act)
		begin
			$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic write_reg(input logic [AXIL_AW-1:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		@(negedge clk);
		axil_req.awaddr  = addr;
		axil_req.wdata   = data;
		axil_req.wstrb   = '1;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid  = 1'b1;
		axil_req.bready  = 1'b0;
		do
			@(posedge clk);
		while (!axil_rsp.awready);
		compare_value("wready with awready", 1, axil_rsp.wready);
		@(negedge clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		// response left pending for a cycle before bready
		@(negedge clk);
		axil_req.bready = 1'b1;
		do
			@(posedge clk);
		while (!axil_rsp.bvalid);
		resp = axil_rsp.bresp;
		@(negedge clk);
		axil_req.bready = 1'b0;
	endtask

	task automatic read_reg(input logic [AXIL_AW-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(negedge clk);
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready  = 1'b1;
		do
			@(posedge clk);
		while (!axil_rsp.arready);
		@(negedge clk);
		axil_req.arvalid = 1'b0;
		do
			@(posedge clk);
		while (!axil_rsp.rvalid);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(negedge clk);
		axil_req.rready = 1'b0;
	endtask

	task automatic readback_reg(input string name, input logic [AXIL_AW-1:0] addr,
		input logic [31:0] mask);
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [1:0]  resp;
		wdata = random_bits(stim_lfsr, 32);
		write_reg(addr, wdata, resp);
		compare_value({name, " write resp"}, RESP_OKAY, resp);
		read_reg(addr, rdata, resp);
		compare_value({name, " read resp"}, RESP_OKAY, resp);
		compare_value({name, " readback"}, wdata & mask, rdata);
	endtask

	task automatic wait_idle();
		logic [31:0] d;
		logic [1:0]  r;
		d = 32'h1;
		while (d[STAT_BUSY_BIT])
			read_reg(REG_STATUS, d, r);
	endtask

	task automatic run_sweep(input int s, input int mode);
		tile_cfg_t   c;
		logic [1:0]  resp;
		logic [31:0] rdata;
		addr_beat_t  b;
		string       tag;
		c.l = 2'(random_bits(stim_lfsr, 2));
		// first eight sweeps walk every phase code
		if (s < 8)
			c.u = phase_e'(3'(s));
		else
			c.u = phase_e'(3'(random_bits(stim_lfsr, 3)));
		c.x      = 4'(random_bits(stim_lfsr, 4));
		c.y      = 4'(random_bits(stim_lfsr, 4));
		c.j      = 2'(random_bits(stim_lfsr, 2));
		c.x_reg5 = 4'(random_bits(stim_lfsr, 4));
		c.y_reg5 = 4'(random_bits(stim_lfsr, 4));
		tag = $sformatf("sweep %0d u=%0d", s, c.u);
		write_reg(REG_CTRL, {27'd0, c.u, c.l}, resp);
		compare_value({tag, " ctrl resp"}, RESP_OKAY, resp);
		write_reg(REG_TILE, {22'd0, c.j, c.y, c.x}, resp);
		compare_value({tag, " tile resp"}, RESP_OKAY, resp);
		write_reg(REG_REG5, {24'd0, c.y_reg5, c.x_reg5}, resp);
		compare_value({tag, " reg5 resp"}, RESP_OKAY, resp);
		ready_mode = mode;
		write_reg(REG_START, 32'd0, resp);
		compare_value({tag, " start resp"}, RESP_OKAY, resp);
		starts++;
		if (mode == MODE_STALL)
		begin
			// output held off, so the sweep is still running here
			write_reg(REG_CTRL, ~{27'd0, c.u, c.l}, resp);
			compare_value({tag, " busy ctrl resp"}, RESP_SLVERR, resp);
			write_reg(REG_TILE, random_bits(stim_lfsr, 32), resp);
			compare_value({tag, " busy tile resp"}, RESP_SLVERR, resp);
			write_reg(REG_START, 32'd0, resp);
			compare_value({tag, " busy start resp"}, RESP_SLVERR, resp);
			read_reg(REG_STATUS, rdata, resp);
			compare_value({tag, " busy status resp"}, RESP_OKAY, resp);
			compare_value({tag, " busy flag"}, 1, rdata[STAT_BUSY_BIT]);
			ready_mode = MODE_RANDOM;
		end
		while (beat_q.size() < SWEEP_LEN)
			@(negedge clk);
		for (int i = 0; i < SWEEP_LEN; i++)
		begin
			b = beat_q.pop_front();
			compare_value($sformatf("%s beat %0d z", tag, i), i, b.z);
			compare_value($sformatf("%s beat %0d last", tag, i), i == SWEEP_LEN - 1, b.last);
			compare_value($sformatf("%s beat %0d addr", tag, i), model_addr(c, i),
				b.addr.flat);
		end
		wait_idle();
		ready_mode = MODE_FULL;
	endtask

	// output ready pattern, about one cycle in four when random
	always @(negedge clk)
	begin
		case (ready_mode)
			MODE_FULL:   out_ready = 1'b1;
			MODE_RANDOM: out_ready = (random_bits(ready_lfsr, 2) == 2'd0);
			default:     out_ready = 1'b0;
		endcase
	end

	always @(posedge clk)
	begin
		if (rst_n && out_valid && out_ready)
		begin
			if (beat_q.size() >= SWEEP_LEN)
				fail_now("an address beat arrived after a sweep was already complete");
			beat_q.push_back(out_beat);
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("[ERROR] the run timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		logic [31:0] rdata;
		logic [1:0]  resp;
		axil_req   = '0;
		out_ready  = 1'b0;
		ready_mode = MODE_FULL;
		starts     = 0;
		stim_lfsr  = 32'h5ba6;
		ready_lfsr = 32'h5ba6;
		@(posedge rst_n);
		for (int i = 0; i < N_READBACK; i++)
		begin
			readback_reg("ctrl", REG_CTRL, 32'h1F);
			readback_reg("tile", REG_TILE, 32'h3FF);
			readback_reg("reg5", REG_REG5, 32'hFF);
		end
		for (int s = 0; s < N_SWEEPS; s++)
		begin
			if (s < 16)
				run_sweep(s, MODE_FULL);
			else if (s < 32)
				run_sweep(s, MODE_RANDOM);
			else
				run_sweep(s, MODE_STALL);
		end
		read_reg(REG_STATUS, rdata, resp);
		compare_value("final status resp", RESP_OKAY, resp);
		compare_value("final busy", 0, rdata[STAT_BUSY_BIT]);
		compare_value("sweep count", starts % 256, rdata[STAT_CNT_LSB +: 8]);
		read_reg(5'h14, rdata, resp);
		compare_value("unknown offset read resp", RESP_SLVERR, resp);
		write_reg(5'h1C, 32'hFFFF_FFFF, resp);
		compare_value("unknown offset write resp", RESP_SLVERR, resp);
		// no beat may follow the last sweep
		compare_value("beats left after the last sweep", 0, beat_q.size());
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/addr_gen_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module addr_gen_properties
	import axil_pkg::*;
	import fmap_pkg::*;
(
	input wire logic       clk,
	input wire logic       rst_n,
	input wire axil_req_t  axil_req,
	input wire axil_rsp_t  axil_rsp,
	input wire addr_beat_t out_beat,
	input wire logic       out_valid,
	input wire logic       out_ready
);

	// stream is empty while in reset
	assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high during reset");

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_beat))
		else $error("out_beat changed or dropped while stalled");

	// write response waits for bready
	assert property (@(posedge clk) disable iff (!rst_n)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
		else $error("bvalid dropped before bready");

endmodule

bind bram_addr_top addr_gen_properties i_props (
	.clk       (clk),
	.rst_n     (rst_n),
	.axil_req  (axil_req),
	.axil_rsp  (axil_rsp),
	.out_beat  (out_beat),
	.out_valid (out_valid),
	.out_ready (out_ready)
);

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD_NS = 4;
	localparam int RESET_CYCLES   = 8;

	initial
	begin
		clk = 1'b0;
		forever
			#(HALF_PERIOD_NS) clk = ~clk;
	end

	// reset released on a falling edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== design/bram_addr_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module bram_addr_top
	import axil_pkg::*;
	import fmap_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  axil_req_t  axil_req,
	output axil_rsp_t  axil_rsp,
	output addr_beat_t out_beat,
	output logic       out_valid,
	input  logic       out_ready
);

	tile_cfg_t  cfg;
	logic       start;
	logic       sweep_done;
	addr_req_t  req;
	logic       req_valid;
	logic       req_ready;
	addr_beat_t beat;
	logic       beat_valid;
	logic       beat_ready;

	axil_cfg_regs i_cfg_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.sweep_done (sweep_done),
		.cfg        (cfg),
		.start      (start)
	);

	sweep_sequencer i_sequencer (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.sweep_done (sweep_done)
	);

	// reads the live config, stable while busy
	bram2_addr_gen i_addr_gen (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.beat       (beat),
		.beat_valid (beat_valid),
		.beat_ready (beat_ready)
	);

	addr_out_fifo i_out_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_beat   (beat),
		.in_valid  (beat_valid),
		.in_ready  (beat_ready),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

`default_nettype wire

// ==== design/addr_out_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module addr_out_fifo
	import fmap_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  addr_beat_t in_beat,
	input  logic       in_valid,
	output logic       in_ready,
	output addr_beat_t out_beat,
	output logic       out_valid,
	input  logic       out_ready
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	addr_beat_t       mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	assign out_valid = (count != '0);
	// full buffer still takes a beat while the head leaves
	assign in_ready  = (count != CNT_W'(FIFO_DEPTH)) || out_ready;
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;
	assign out_beat  = mem[rd_ptr];

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_beat;
	end

endmodule

`default_nettype wire

// ==== design/bram2_addr_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module bram2_addr_gen
	import fmap_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  tile_cfg_t  cfg,
	input  addr_req_t  req,
	input  logic       req_valid,
	output logic       req_ready,
	output addr_beat_t beat,
	output logic       beat_valid,
	input  logic       beat_ready
);

	localparam logic [FIELD_W-1:0] OFF_8  = FIELD_W'(8);
	localparam logic [FIELD_W-1:0] OFF_16 = FIELD_W'(16);
	localparam logic [FIELD_W-1:0] OFF_24 = FIELD_W'(24);

	logic [FIELD_W-1:0] x_w;
	logic [FIELD_W-1:0] y_w;
	logic [FIELD_W-1:0] xr_w;
	logic [FIELD_W-1:0] yr_w;
	logic [FIELD_W-1:0] h_w;
	logic [FIELD_W-1:0] k_w;
	logic [FIELD_W-1:0] j_w;
	logic [FIELD_W-1:0] l_off;
	bram2_addr_u        addr_nxt;
	logic               take;

	assign x_w  = FIELD_W'(cfg.x);
	assign y_w  = FIELD_W'(cfg.y);
	assign xr_w = FIELD_W'(cfg.x_reg5);
	assign yr_w = FIELD_W'(cfg.y_reg5);
	assign j_w  = FIELD_W'(cfg.j);
	// halved registered coordinates for phases 0 and 1
	assign h_w  = xr_w >> 1;
	assign k_w  = yr_w >> 1;
	// layer slot picks a column quarter
	assign l_off = {cfg.l, 3'b000};

	// every field sum wraps mod 32
	always_comb
	begin
		addr_nxt.flat = '0;
		case (cfg.u)
			PH_LIVE:
			begin
				addr_nxt.rc.row = x_w;
				addr_nxt.rc.col = y_w + l_off;
			end
			PH_STRIDE:
			begin
				addr_nxt.rc.row = x_w + j_w - FIELD_W'(1);
				addr_nxt.rc.col = y_w + l_off;
			end
			PH_REG5:
				case (req.z)
					3'd2: addr_nxt.rc = '{xr_w, yr_w};
					3'd3: addr_nxt.rc = '{xr_w, yr_w + OFF_8};
					3'd4: addr_nxt.rc = '{xr_w, yr_w + OFF_16};
					3'd5: addr_nxt.rc = '{xr_w, yr_w + OFF_24};
					// lower half of the block, wraps round through z 0 and 1
					3'd6: addr_nxt.rc = '{xr_w + OFF_8, yr_w};
					3'd7: addr_nxt.rc = '{xr_w + OFF_8, yr_w + OFF_8};
					3'd0: addr_nxt.rc = '{xr_w + OFF_8, yr_w + OFF_16};
					default: addr_nxt.rc = '{xr_w + OFF_8, yr_w + OFF_24};
				endcase
			PH_HALF0:
				case (req.z)
					3'd2: addr_nxt.rc = '{h_w, k_w};
					3'd3: addr_nxt.rc = '{h_w, k_w + OFF_8};
					3'd4: addr_nxt.rc = '{h_w, k_w + OFF_16};
					3'd5: addr_nxt.rc = '{h_w, k_w + OFF_24};
					3'd6: addr_nxt.rc = '{h_w + OFF_8, k_w};
					3'd7: addr_nxt.rc = '{h_w + OFF_8, k_w + OFF_8};
					3'd0: addr_nxt.rc = '{h_w, k_w + OFF_16};
					default: addr_nxt.rc = '{h_w, k_w + OFF_24};
				endcase
			PH_HALF1:
				case (req.z)
					3'd0: addr_nxt.rc = '{h_w + OFF_8, k_w + OFF_16};
					3'd1: addr_nxt.rc = '{h_w + OFF_8, k_w + OFF_24};
					3'd2: addr_nxt.rc = '{h_w, k_w};
					3'd3: addr_nxt.rc = '{h_w, k_w + OFF_8};
					default: addr_nxt.flat = '0;
				endcase
			// phases 3, 6 and 7 touch one row only
			default:
				case (req.z)
					3'd1: addr_nxt.rc = '{xr_w, yr_w};
					3'd2: addr_nxt.rc = '{xr_w, yr_w + OFF_8};
					3'd3: addr_nxt.rc = '{xr_w, yr_w + OFF_16};
					3'd0: addr_nxt.rc = '{xr_w, yr_w + OFF_24};
					default: addr_nxt.flat = '0;
				endcase
		endcase
	end

	// single output stage, refill while draining
	assign req_ready = !beat_valid || beat_ready;
	assign take      = req_valid && req_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			beat_valid <= 1'b0;
		else if (take)
			beat_valid <= 1'b1;
		else if (beat_ready)
			beat_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (take)
			beat <= '{addr: addr_nxt, z: req.z, last: req.last};
	end

endmodule

`default_nettype wire

// ==== design/sweep_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module sweep_sequencer
	import fmap_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      start,
	output addr_req_t req,
	output logic      req_valid,
	input  logic      req_ready,
	output logic      sweep_done
);

	logic           active_q;
	logic [Z_W-1:0] z_q;
	logic           last_z;
	logic           fire;

	assign last_z = (z_q == Z_W'(SWEEP_LEN - 1));
	assign fire   = active_q && req_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active_q   <= 1'b0;
			z_q        <= '0;
			sweep_done <= 1'b0;
		end
		else
		begin
			// pulse once the last sub-block has been taken
			sweep_done <= fire && last_z;
			if (!active_q)
			begin
				if (start)
				begin
					active_q <= 1'b1;
					z_q      <= '0;
				end
			end
			else if (req_ready)
			begin
				if (last_z)
				begin
					active_q <= 1'b0;
					z_q      <= '0;
				end
				else
				begin
					z_q <= z_q + 1'b1;
				end
			end
		end
	end

	// z holds while the generator stalls
	assign req_valid = active_q;
	assign req       = '{z: z_q, last: last_z};

endmodule

`default_nettype wire

// ==== design/axil_cfg_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_cfg_regs
	import axil_pkg::*;
	import fmap_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	input  logic      sweep_done,
	output tile_cfg_t cfg,
	output logic      start
);

	tile_cfg_t           cfg_q;
	logic                busy_q;
	logic [7:0]          sweep_cnt_q;
	logic                start_q;
	logic                bvalid_q;
	logic [1:0]          bresp_q;
	logic                rvalid_q;
	logic [1:0]          rresp_q;
	logic [AXIL_DW-1:0]  rdata_q;
	logic                wr_fire;
	logic                rd_fire;
	logic                wr_known;
	logic                wr_ok;
	logic                rd_known;
	logic [REG_BITS-1:0] ctrl_img;
	logic [REG_BITS-1:0] tile_img;
	logic [REG_BITS-1:0] reg5_img;
	logic [REG_BITS-1:0] status_img;
	logic [REG_BITS-1:0] wr_cur;
	logic [REG_BITS-1:0] wr_mask;
	logic [REG_BITS-1:0] wr_val;
	logic [REG_BITS-1:0] rd_img;

	// one write in flight, one read in flight
	assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
	assign rd_fire = axil_req.arvalid && !rvalid_q;

	// register words as seen on the bus
	assign ctrl_img = (REG_BITS'(cfg_q.l) << CTRL_L_LSB) | (REG_BITS'(cfg_q.u) << CTRL_U_LSB);
	assign tile_img = (REG_BITS'(cfg_q.x) << TILE_X_LSB) | (REG_BITS'(cfg_q.y) << TILE_Y_LSB) |
		(REG_BITS'(cfg_q.j) << TILE_J_LSB);
	assign reg5_img = (REG_BITS'(cfg_q.x_reg5) << REG5_X_LSB) |
		(REG_BITS'(cfg_q.y_reg5) << REG5_Y_LSB);
	assign status_img = (REG_BITS'(busy_q) << STAT_BUSY_BIT) |
		(REG_BITS'(sweep_cnt_q) << STAT_CNT_LSB);

	// start and status hold no writable bits
	always_comb
	begin
		wr_known = 1'b1;
		case (axil_req.awaddr)
			REG_CTRL:   wr_cur = ctrl_img;
			REG_TILE:   wr_cur = tile_img;
			REG_REG5:   wr_cur = reg5_img;
			REG_START,
			REG_STATUS: wr_cur = '0;
			default:
			begin
				wr_cur   = '0;
				wr_known = 1'b0;
			end
		endcase
	end

	// config is frozen for the whole sweep
	assign wr_ok   = wr_known && !busy_q;
	assign wr_mask = {{8{axil_req.wstrb[2]}}, {8{axil_req.wstrb[1]}}, {8{axil_req.wstrb[0]}}};
	assign wr_val  = (wr_cur & ~wr_mask) | (axil_req.wdata[REG_BITS-1:0] & wr_mask);

	always_comb
	begin
		rd_known = 1'b1;
		case (axil_req.araddr)
			REG_CTRL:   rd_img = ctrl_img;
			REG_TILE:   rd_img = tile_img;
			REG_REG5:   rd_img = reg5_img;
			REG_START:  rd_img = '0;
			REG_STATUS: rd_img = status_img;
			default:
			begin
				rd_img   = '0;
				rd_known = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cfg_q       <= '0;
			busy_q      <= 1'b0;
			sweep_cnt_q <= '0;
			start_q     <= 1'b0;
			bvalid_q    <= 1'b0;
			rvalid_q    <= 1'b0;
		end
		else
		begin
			start_q <= 1'b0;
			if (wr_fire)
				bvalid_q <= 1'b1;
			else if (axil_req.bready)
				bvalid_q <= 1'b0;
			if (rd_fire)
				rvalid_q <= 1'b1;
			else if (axil_req.rready)
				rvalid_q <= 1'b0;
			if (wr_fire && wr_ok)
			begin
				case (axil_req.awaddr)
					REG_CTRL:
					begin
						cfg_q.l <= wr_val[CTRL_L_LSB +: 2];
						cfg_q.u <= phase_e'(wr_val[CTRL_U_LSB +: 3]);
					end
					REG_TILE:
					begin
						cfg_q.x <= wr_val[TILE_X_LSB +: COORD_W];
						cfg_q.y <= wr_val[TILE_Y_LSB +: COORD_W];
						cfg_q.j <= wr_val[TILE_J_LSB +: 2];
					end
					REG_REG5:
					begin
						cfg_q.x_reg5 <= wr_val[REG5_X_LSB +: COORD_W];
						cfg_q.y_reg5 <= wr_val[REG5_Y_LSB +: COORD_W];
					end
					REG_START:
					begin
						busy_q  <= 1'b1;
						start_q <= 1'b1;
					end
					default: ;
				endcase
			end
			// sweep count wraps at 256
			if (sweep_done)
			begin
				busy_q      <= 1'b0;
				sweep_cnt_q <= sweep_cnt_q + 8'd1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_fire)
			bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		if (rd_fire)
		begin
			rdata_q <= AXIL_DW'(rd_img);
			rresp_q <= rd_known ? RESP_OKAY : RESP_SLVERR;
		end
	end

	always_comb
	begin
		axil_rsp.awready = wr_fire;
		axil_rsp.wready  = wr_fire;
		axil_rsp.bvalid  = bvalid_q;
		axil_rsp.bresp   = bresp_q;
		axil_rsp.arready = !rvalid_q;
		axil_rsp.rvalid  = rvalid_q;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = rresp_q;
	end

	assign cfg   = cfg_q;
	assign start = start_q;

endmodule

`default_nettype wire

// ==== design/axil_pkg.sv ====
`default_nettype none

package axil_pkg;

	localparam int AXIL_AW  = 5;
	localparam int AXIL_DW  = 32;
	// stored bits per register, low three bytes
	localparam int REG_BITS = 24;

	localparam logic [AXIL_AW-1:0] REG_CTRL   = 5'h00;
	localparam logic [AXIL_AW-1:0] REG_TILE   = 5'h04;
	localparam logic [AXIL_AW-1:0] REG_REG5   = 5'h08;
	localparam logic [AXIL_AW-1:0] REG_START  = 5'h0C;
	localparam logic [AXIL_AW-1:0] REG_STATUS = 5'h10;

	// field positions in the register words
	localparam int CTRL_L_LSB    = 0;
	localparam int CTRL_U_LSB    = 2;
	localparam int TILE_X_LSB    = 0;
	localparam int TILE_Y_LSB    = 4;
	localparam int TILE_J_LSB    = 8;
	localparam int REG5_X_LSB    = 0;
	localparam int REG5_Y_LSB    = 4;
	localparam int STAT_BUSY_BIT = 0;
	localparam int STAT_CNT_LSB  = 8;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic                 awvalid;
		logic [AXIL_AW-1:0]   awaddr;
		logic                 wvalid;
		logic [AXIL_DW-1:0]   wdata;
		logic [AXIL_DW/8-1:0] wstrb;
		logic                 bready;
		logic                 arvalid;
		logic [AXIL_AW-1:0]   araddr;
		logic                 rready;
	} axil_req_t;

	typedef struct packed {
		logic               awready;
		logic               wready;
		logic               bvalid;
		logic [1:0]         bresp;
		logic               arready;
		logic               rvalid;
		logic [AXIL_DW-1:0] rdata;
		logic [1:0]         rresp;
	} axil_rsp_t;

endpackage

`default_nettype wire

// ==== design/fmap_pkg.sv ====
`default_nettype none

package fmap_pkg;

	// tile and address geometry
	localparam int COORD_W    = 4;
	localparam int FIELD_W    = 5;
	localparam int ADDR_W     = 2 * FIELD_W;
	localparam int SWEEP_LEN  = 8;
	localparam int Z_W        = $clog2(SWEEP_LEN);
	localparam int FIFO_DEPTH = 4;

	// phase code u
	typedef enum logic [2:0] {
		PH_HALF0  = 3'd0,
		PH_HALF1  = 3'd1,
		PH_LIVE   = 3'd2,
		PH_REG3   = 3'd3,
		PH_STRIDE = 3'd4,
		PH_REG5   = 3'd5,
		PH_REG6   = 3'd6,
		PH_REG7   = 3'd7
	} phase_e;

	typedef struct packed {
		logic [1:0]         l;
		phase_e             u;
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
		logic [COORD_W-1:0] x_reg5;
		logic [COORD_W-1:0] y_reg5;
		logic [1:0]         j;
	} tile_cfg_t;

	typedef struct packed {
		logic [FIELD_W-1:0] row;
		logic [FIELD_W-1:0] col;
	} bram2_rc_t;

	// one bram2 word, flat index or {row, col}
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		bram2_rc_t         rc;
	} bram2_addr_u;

	typedef struct packed {
		logic [Z_W-1:0] z;
		logic           last;
	} addr_req_t;

	typedef struct packed {
		bram2_addr_u    addr;
		logic [Z_W-1:0] z;
		logic           last;
	} addr_beat_t;

endpackage

`default_nettype wire
